// File: design/round_settings.svh
`ifndef ROUND_SETTINGS_SVH
`define ROUND_SETTINGS_SVH

// single precision significand
// hidden bit plus 23 stored fraction bits
`define SIG_W 24

// guard, round and sticky below the significand
`define GUARD_W 3

// full operand significand as it leaves the adder or multiplier
`define RAW_W (`SIG_W + `GUARD_W)

`endif

// File: design/round_pkg.sv
`include "round_settings.svh"

package round_pkg;

    // rounded significand including the hidden bit
    typedef logic [`SIG_W-1:0] sig_t;

    // bits below the significand lsb, msb is guard, lsb is sticky
    typedef logic [`GUARD_W-1:0] guard_t;

    // IEEE 754 rounding direction
    typedef enum logic [1:0] {
        mode_nearest_even = 2'd0,
        mode_toward_zero  = 2'd1,
        mode_toward_pos   = 2'd2,
        mode_toward_neg   = 2'd3
    } round_mode_e;

    // operand as presented to the unit
    typedef struct packed {
        sig_t        sig;
        guard_t      guard;
        round_mode_e mode;
        logic        sign;
    } round_in_t;

    // decision stage output
    typedef struct packed {
        sig_t sig;
        logic inc;
        logic inexact;
    } round_stage_t;

    // final rounded result with flags
    typedef struct packed {
        sig_t sig;
        logic ovf;
        logic inexact;
    } round_out_t;

endpackage

// File: design/round_decide.sv
`timescale 1ns/1ps

module round_decide
    import round_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         in_valid,
    input  round_in_t    operand,
    output logic         stage_valid,
    output round_stage_t stage
);

    // named views of the bits around the rounding point
    logic guard_bit;
    logic round_bit;
    logic sticky_bit;
    logic lsb;
    logic any_guard;
    logic above_half;
    logic tie_odd;
    logic round_up_near;
    logic away_from_zero;
    logic inc;

    assign guard_bit  = operand.guard[2];
    assign round_bit  = operand.guard[1];
    assign sticky_bit = operand.guard[0];
    assign lsb        = operand.sig[0];

    // anything dropped below the lsb makes the result inexact
    assign any_guard = guard_bit | round_bit | sticky_bit;

    // strictly more than half an ulp
    assign above_half = guard_bit & (round_bit | sticky_bit);

    // exactly half an ulp on an odd significand goes up to even
    assign tie_odd = guard_bit & ~round_bit & ~sticky_bit & lsb;

    assign round_up_near = above_half | tie_odd;

    // directed modes only move the magnitude up on their own side
    always_comb begin
        case (operand.mode)
            mode_toward_pos: away_from_zero = ~operand.sign;
            mode_toward_neg: away_from_zero = operand.sign;
            default:         away_from_zero = 1'b0;
        endcase
    end

    always_comb begin
        case (operand.mode)
            mode_nearest_even: inc = round_up_near;
            mode_toward_zero:  inc = 1'b0;
            mode_toward_pos:   inc = away_from_zero & any_guard;
            mode_toward_neg:   inc = away_from_zero & any_guard;
            default:           inc = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= in_valid;
        end
    end

    // payload only loads with a valid operand
    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= '0;
        end else if (in_valid) begin
            stage.sig     <= operand.sig;
            stage.inc     <= inc;
            stage.inexact <= any_guard;
        end
    end

    // an increment is only ever taken when bits were dropped
    property p_inc_implies_inexact;
        @(posedge clk) disable iff (reset)
        stage_valid && stage.inc |-> stage.inexact;
    endproperty

    a_inc_implies_inexact: assert property (p_inc_implies_inexact)
        else $error("round_decide: increment without inexact at %0t", $time);

endmodule

// File: design/round_increment.sv
`timescale 1ns/1ps

`include "round_settings.svh"

module round_increment
    import round_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         stage_valid,
    input  round_stage_t stage,
    output logic         out_valid,
    output round_out_t   result
);

    // one extra bit to catch the carry out of the msb
    logic [`SIG_W:0] sum;
    logic            carry;
    sig_t            sig_next;

    assign sum   = {1'b0, stage.sig} + {{`SIG_W{1'b0}}, stage.inc};
    assign carry = sum[`SIG_W];

    // on carry the significand wrapped to all zeros,
    // shifting right brings the carry back in as the hidden bit
    always_comb begin
        if (carry) begin
            sig_next = sum[`SIG_W:1];
        end else begin
            sig_next = sum[`SIG_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= stage_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else if (stage_valid) begin
            result.sig     <= sig_next;
            result.ovf     <= carry;
            result.inexact <= stage.inexact;
        end
    end

    // renormalized value is the hidden bit alone
    property p_ovf_value;
        @(posedge clk) disable iff (reset)
        out_valid && result.ovf |-> result.sig == {1'b1, {(`SIG_W-1){1'b0}}};
    endproperty

    a_ovf_value: assert property (p_ovf_value)
        else $error("round_increment: bad significand on overflow at %0t", $time);

    // overflow needs an increment, which the decision stage only
    // grants for an inexact operand
    property p_ovf_inexact;
        @(posedge clk) disable iff (reset)
        out_valid && result.ovf |-> result.inexact;
    endproperty

    a_ovf_inexact: assert property (p_ovf_inexact)
        else $error("round_increment: overflow on exact result at %0t", $time);

    // every result comes from a stage entry one cycle earlier
    property p_valid_source;
        @(posedge clk) disable iff (reset)
        out_valid |-> $past(stage_valid);
    endproperty

    a_valid_source: assert property (p_valid_source)
        else $error("round_increment: spurious result at %0t", $time);

endmodule

// File: design/round_unit.sv
`timescale 1ns/1ps

module round_unit
    import round_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid,
    input  round_in_t  operand,
    output logic       out_valid,
    output round_out_t result
);

    // between decision and increment
    logic         stage_valid;
    round_stage_t stage;

    // stage 1, decide whether to bump the significand
    round_decide u_decide (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .operand     (operand),
        .stage_valid (stage_valid),
        .stage       (stage)
    );

    // stage 2, add and renormalize
    round_increment u_increment (
        .clk         (clk),
        .reset       (reset),
        .stage_valid (stage_valid),
        .stage       (stage),
        .out_valid   (out_valid),
        .result      (result)
    );

endmodule

// File: bench/round_unit_tb.sv
`timescale 1ns/1ps

`include "round_settings.svh"

module round_unit_tb
    import round_pkg::*;
;

    logic       clk;
    logic       reset;
    logic       in_valid;
    round_in_t  operand;
    logic       out_valid;
    round_out_t result;

    // expected results and the cycle each one is due, in issue order
    round_out_t expected_q[$];
    int         due_q[$];

    int         cycle = 0;
    int         issued_count = 0;
    int         checked_count = 0;
    integer     seed = 31;
    round_out_t exp_res;
    int         exp_cycle;

    round_unit dut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .operand   (operand),
        .out_valid (out_valid),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task abort_run;
        $display("tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    // rounding rules per mode, written out independently of the DUT
    function automatic round_out_t ref_round(input round_in_t op);
        logic            inc;
        logic            any_dropped;
        logic [`SIG_W:0] sum;
        round_out_t      r;
        any_dropped = |op.guard;
        case (op.mode)
            mode_nearest_even: inc = op.guard[2] & (op.guard[1] | op.guard[0] | op.sig[0]);
            mode_toward_zero:  inc = 1'b0;
            mode_toward_pos:   inc = ~op.sign & any_dropped;
            default:           inc = op.sign & any_dropped;
        endcase
        sum = {1'b0, op.sig} + {{`SIG_W{1'b0}}, inc};
        r.inexact = any_dropped;
        r.ovf = sum[`SIG_W];
        if (r.ovf) begin
            r.sig = {1'b1, {(`SIG_W-1){1'b0}}};
        end else begin
            r.sig = sum[`SIG_W-1:0];
        end
        return r;
    endfunction

    function automatic round_in_t make_operand(input sig_t sig, input guard_t guard,
                                               input round_mode_e mode, input logic sign);
        round_in_t op;
        op.sig = sig;
        op.guard = guard;
        op.mode = mode;
        op.sign = sign;
        return op;
    endfunction

    // result lands at the negedge three counter steps after the issuing edge
    task automatic issue_operand(input round_in_t op);
        @(posedge clk);
        in_valid <= 1'b1;
        operand  <= op;
        expected_q.push_back(ref_round(op));
        due_q.push_back(cycle + 3);
        issued_count++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    task automatic wait_for_drain(input int limit);
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        if (expected_q.size() != 0) begin
            $display("no result arrived within %0d cycles, %0d results still missing",
                     limit, expected_q.size());
            abort_run();
        end
    endtask

    // hand-worked expectation checked against the reference, then run alone
    task automatic run_directed(input round_in_t op, input sig_t exp_sig,
                                input logic exp_ovf, input logic exp_inexact);
        round_out_t want;
        round_out_t got;
        want.sig = exp_sig;
        want.ovf = exp_ovf;
        want.inexact = exp_inexact;
        got = ref_round(op);
        assert (got == want) else begin
            $display("** Error at %0t: reference gives sig %h ovf %b inexact %b, expected %h %b %b",
                     $time, got.sig, got.ovf, got.inexact, want.sig, want.ovf, want.inexact);
            abort_run();
        end
        issue_operand(op);
        idle_cycles(1);
        wait_for_drain(10);
        idle_cycles(2);
    endtask

    task automatic run_stream(input int count);
        logic [31:0] rnd;
        logic [31:0] ctl;
        round_in_t   op;
        int          gap;
        for (int n = 0; n < count; n++) begin
            rnd = $random(seed);
            ctl = $random(seed);
            op.sig = rnd[`SIG_W-1:0];
            op.guard = rnd[26:24];
            op.mode = round_mode_e'(rnd[28:27]);
            op.sign = rnd[29];
            // all ones now and then to hit the carry out
            if (ctl[5:3] == 3'd0) begin
                op.sig = '1;
            end
            issue_operand(op);
            if (ctl[2]) begin
                gap = 0;
            end else begin
                gap = int'(ctl[1:0]);
            end
            idle_cycles(gap);
        end
        idle_cycles(1);
    endtask

    always @(negedge clk) begin
        if (reset) begin
            assert (out_valid === 1'b0) else begin
                $display("** Error at %0t: out_valid is %b during reset", $time, out_valid);
                abort_run();
            end
        end else if (out_valid) begin
            if (expected_q.size() == 0) begin
                $display("a result came out with no operand waiting for it at %0t", $time);
                abort_run();
            end else begin
                exp_res = expected_q.pop_front();
                exp_cycle = due_q.pop_front();
                assert (cycle == exp_cycle) else begin
                    $display("** Error at %0t: result arrived in cycle %0d, expected cycle %0d",
                             $time, cycle, exp_cycle);
                    abort_run();
                end
                assert (result == exp_res) else begin
                    $display("** Error at %0t: got sig %h ovf %b inexact %b, expected %h %b %b",
                             $time, result.sig, result.ovf, result.inexact,
                             exp_res.sig, exp_res.ovf, exp_res.inexact);
                    abort_run();
                end
                checked_count++;
            end
        end
    end

    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        operand = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        // quiet period, any out_valid here has no operand behind it
        idle_cycles(5);

        // ties go to even, above half always rounds up
        run_directed(make_operand(24'h000003, 3'b100, mode_nearest_even, 1'b0),
                     24'h000004, 1'b0, 1'b1);
        run_directed(make_operand(24'h000002, 3'b100, mode_nearest_even, 1'b0),
                     24'h000002, 1'b0, 1'b1);
        run_directed(make_operand(24'h000002, 3'b101, mode_nearest_even, 1'b1),
                     24'h000003, 1'b0, 1'b1);
        run_directed(make_operand(24'h000002, 3'b110, mode_nearest_even, 1'b0),
                     24'h000003, 1'b0, 1'b1);
        run_directed(make_operand(24'h000003, 3'b011, mode_nearest_even, 1'b0),
                     24'h000003, 1'b0, 1'b1);

        // directed modes
        run_directed(make_operand(24'h123457, 3'b111, mode_toward_zero, 1'b0),
                     24'h123457, 1'b0, 1'b1);
        run_directed(make_operand(24'h123457, 3'b111, mode_toward_zero, 1'b1),
                     24'h123457, 1'b0, 1'b1);
        run_directed(make_operand(24'h123456, 3'b001, mode_toward_pos, 1'b0),
                     24'h123457, 1'b0, 1'b1);
        run_directed(make_operand(24'h123456, 3'b001, mode_toward_pos, 1'b1),
                     24'h123456, 1'b0, 1'b1);
        run_directed(make_operand(24'h123456, 3'b010, mode_toward_neg, 1'b1),
                     24'h123457, 1'b0, 1'b1);
        run_directed(make_operand(24'h123456, 3'b010, mode_toward_neg, 1'b0),
                     24'h123456, 1'b0, 1'b1);
        for (int m = 0; m < 4; m++) begin
            run_directed(make_operand(24'hABCDEF, 3'b000, round_mode_e'(m[1:0]), 1'b1),
                         24'hABCDEF, 1'b0, 1'b0);
        end

        // carry out of the msb
        run_directed(make_operand(24'hFFFFFF, 3'b100, mode_nearest_even, 1'b0),
                     24'h800000, 1'b1, 1'b1);
        run_directed(make_operand(24'hFFFFFF, 3'b100, mode_toward_zero, 1'b0),
                     24'hFFFFFF, 1'b0, 1'b1);
        run_directed(make_operand(24'hFFFFFF, 3'b001, mode_toward_pos, 1'b0),
                     24'h800000, 1'b1, 1'b1);

        run_stream(2000);
        wait_for_drain(20);
        idle_cycles(5);

        if (expected_q.size() == 0 && checked_count == issued_count) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("issued %0d operands but checked %0d results", issued_count, checked_count);
            abort_run();
        end
    end

endmodule

// File: list.f
+incdir+design
design/round_pkg.sv
design/round_decide.sv
design/round_increment.sv
design/round_unit.sv
bench/round_unit_tb.sv

// File: run.sh
#!/bin/sh
# build and run the rounding unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module round_unit_tb \
    -o round_unit_sim > build.log 2>&1 \
    || { cat build.log; echo "compile failed"; exit 1; }

./obj_dir/round_unit_sim > sim.log 2>&1
cat sim.log

grep -q "tests failed" sim.log && exit 1
grep -q "all tests passed" sim.log || { echo "simulation ended without a verdict"; exit 1; }
exit 0
